// ==== hdl/sd_block_writer.sv ====
`timescale 1ns/1ps

module sd_block_writer (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  sd_pkg::sd_job_t     job,
    output sd_pkg::sd_status_t  status,
    output logic                cs,
    output logic                sh_go,
    output logic [7:0]          sh_tx,
    input  logic [7:0]          sh_rx,
    input  logic                sh_done,
    output logic                pat_load,
    output logic                pat_next,
    input  logic [7:0]          pat_byte,
    input  logic                pat_last
);

    typedef enum logic [3:0] {
        st_idle, st_cmd, st_r1, st_gap, st_token, st_data, st_crc, st_dresp, st_busy, st_tail
    } state_t;

    localparam logic [11:0] r1_last   = 12'(sd_pkg::r1_poll_limit - 1);
    localparam logic [11:0] busy_last = 12'(sd_pkg::busy_poll_limit - 1);

    state_t      state;
    logic        wait_sh;             // Byte in flight on the shifter
    logic [2:0]  byte_idx;
    logic [11:0] poll_cnt;
    logic [7:0]  sectors_left;
    logic [31:0] addr;                // Byte address of current sector
    logic        last_q;
    logic [7:0]  cmd_byte;
    logic [7:0]  tx_next;
    logic        fail_now;

    // CMD24 frame with byte address, CRC sent as FF
    always_comb begin
        case (byte_idx)
            3'd0:    cmd_byte = sd_pkg::cmd24;
            3'd1:    cmd_byte = addr[31:24];
            3'd2:    cmd_byte = addr[23:16];
            3'd3:    cmd_byte = addr[15:8];
            3'd4:    cmd_byte = addr[7:0];
            default: cmd_byte = 8'hFF;
        endcase
    end

    always_comb begin
        case (state)
            st_cmd:   tx_next = cmd_byte;
            st_token: tx_next = sd_pkg::start_token;
            st_data:  tx_next = pat_byte;
            default:  tx_next = 8'hFF;   // Polls, gap, CRC, tail
        endcase
    end

    // Response judgement on the byte just received
    always_comb begin
        fail_now = 1'b0;
        if (sh_done) begin
            case (state)
                st_r1:    fail_now = sh_rx[7] ? (poll_cnt == r1_last) : (sh_rx != 8'h00);
                st_dresp: fail_now = (sh_rx & sd_pkg::data_resp_mask) != sd_pkg::data_resp_ok;
                st_busy:  fail_now = (sh_rx != 8'hFF) && (poll_cnt == busy_last);
                default:  fail_now = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= st_idle;
            status       <= '0;
            cs           <= 1'b1;
            sh_go        <= 1'b0;
            sh_tx        <= 8'hFF;
            pat_load     <= 1'b0;
            pat_next     <= 1'b0;
            wait_sh      <= 1'b0;
            byte_idx     <= '0;
            poll_cnt     <= '0;
            sectors_left <= '0;
            addr         <= '0;
            last_q       <= 1'b0;
        end else begin
            sh_go    <= 1'b0;
            pat_load <= 1'b0;
            pat_next <= 1'b0;
            if (state == st_idle) begin
                if (start) begin
                    status.done         <= (job.sector_count == 8'd0);
                    status.err          <= 1'b0;
                    status.sectors_done <= '0;
                    addr                <= {job.start_sector[22:0], 9'd0};
                    sectors_left        <= job.sector_count;
                    if (job.sector_count != 8'd0) begin
                        status.busy <= 1'b1;
                        cs          <= 1'b0;
                        pat_load    <= 1'b1;
                        byte_idx    <= '0;
                        state       <= st_cmd;
                    end
                end
            end else if (!wait_sh) begin
                sh_go   <= 1'b1;
                sh_tx   <= tx_next;
                wait_sh <= 1'b1;
                if (state == st_data) begin
                    pat_next <= 1'b1;
                    last_q   <= pat_last;
                end
            end else if (fail_now) begin
                wait_sh     <= 1'b0;
                status.busy <= 1'b0;
                status.err  <= 1'b1;
                cs          <= 1'b1;
                state       <= st_idle;
            end else if (sh_done) begin
                wait_sh <= 1'b0;
                case (state)
                    st_cmd: begin
                        byte_idx <= byte_idx + 3'd1;
                        poll_cnt <= '0;
                        if (byte_idx == 3'd5) state <= st_r1;
                    end
                    st_r1: begin
                        poll_cnt <= poll_cnt + 12'd1;
                        if (!sh_rx[7]) state <= st_gap;   // R1 of 00 arrived
                    end
                    st_gap:   state <= st_token;
                    st_token: state <= st_data;
                    st_data: begin
                        byte_idx <= '0;
                        if (last_q) state <= st_crc;
                    end
                    st_crc: begin
                        byte_idx <= byte_idx + 3'd1;
                        if (byte_idx == 3'd1) state <= st_dresp;
                    end
                    st_dresp: begin
                        status.sectors_done <= status.sectors_done + 8'd1;
                        poll_cnt            <= '0;
                        state               <= st_busy;
                    end
                    st_busy: begin
                        poll_cnt <= poll_cnt + 12'd1;
                        if (sh_rx == 8'hFF) begin
                            cs    <= 1'b1;               // Release card for one byte
                            state <= st_tail;
                        end
                    end
                    st_tail: begin
                        sectors_left <= sectors_left - 8'd1;
                        if (sectors_left == 8'd1) begin
                            status.busy <= 1'b0;
                            status.done <= 1'b1;
                            state       <= st_idle;
                        end else begin
                            addr     <= addr + 32'(sd_pkg::sector_bytes);
                            cs       <= 1'b0;
                            pat_load <= 1'b1;
                            byte_idx <= '0;
                            state    <= st_cmd;
                        end
                    end
                    default: state <= st_idle;
                endcase
            end
        end
    end

    a_cs_high_idle: assert property (@(posedge clk) disable iff (rst) (state == st_idle) |-> cs);

endmodule

// ==== hdl/sd_pkg.sv ====
package sd_pkg;

    // Job handed from the register block to the writer
    typedef struct packed {
        logic [31:0] start_sector;
        logic [7:0]  sector_count;
        logic [7:0]  seed;            // First data byte of each sector
    } sd_job_t;

    typedef struct packed {
        logic       busy;
        logic       done;
        logic       err;
        logic [7:0] sectors_done;     // Sectors with accepted data response
    } sd_status_t;

    typedef struct packed {
        logic        we;
        logic [1:0]  addr;
        logic [31:0] wdata;
    } cfg_req_t;

    // Register map
    localparam logic [1:0] reg_start = 2'd0;
    localparam logic [1:0] reg_count = 2'd1;
    localparam logic [1:0] reg_seed  = 2'd2;
    localparam logic [1:0] reg_ctrl  = 2'd3;

    // SD SPI protocol bytes
    localparam logic [7:0] cmd24          = 8'h58;
    localparam logic [7:0] start_token    = 8'hFE;
    localparam logic [7:0] data_resp_mask = 8'h1F;
    localparam logic [7:0] data_resp_ok   = 8'h05;

    localparam int sector_bytes    = 512;
    localparam int r1_poll_limit   = 8;      // Bytes
    localparam int busy_poll_limit = 4096;   // Bytes

endpackage

// ==== hdl/sd_write_regs.sv ====
`timescale 1ns/1ps

module sd_write_regs (
    input  logic                clk,
    input  logic                rst,
    input  logic                req,
    input  sd_pkg::cfg_req_t    cfg_req,
    output logic                ack,
    output logic [31:0]         rdata,
    output sd_pkg::sd_job_t     job,
    output logic                start,
    input  sd_pkg::sd_status_t  status
);

    logic new_req;                    // First cycle of a request

    assign new_req = req && !ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack   <= 1'b0;
            start <= 1'b0;
            job   <= '0;
            rdata <= '0;
        end else begin
            start <= 1'b0;
            ack   <= req;                // Follows req one cycle later
            if (new_req && cfg_req.we) begin
                case (cfg_req.addr)
                    sd_pkg::reg_start: job.start_sector <= cfg_req.wdata;
                    sd_pkg::reg_count: job.sector_count <= cfg_req.wdata[7:0];
                    sd_pkg::reg_seed:  job.seed         <= cfg_req.wdata[7:0];
                    default: begin
                        // Go is dropped while a job runs
                        if (cfg_req.wdata[0] && !status.busy) start <= 1'b1;
                    end
                endcase
            end else if (new_req) begin
                case (cfg_req.addr)
                    sd_pkg::reg_start: rdata <= job.start_sector;
                    sd_pkg::reg_count: rdata <= {24'd0, job.sector_count};
                    sd_pkg::reg_seed:  rdata <= {24'd0, job.seed};
                    default:           rdata <= {21'd0, status};
                endcase
            end
        end
    end

    // Host holds the request fields while req stays high
    a_cfg_stable_during_req: assert property (@(posedge clk) disable iff (rst)
        req && $past(req) |-> $stable(cfg_req));

endmodule

// ==== hdl/sd_write_test_top.sv ====
`timescale 1ns/1ps

module sd_write_test_top #(
    parameter int clk_div = 2
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              req,
    input  sd_pkg::cfg_req_t  cfg_req,
    output logic              ack,
    output logic [31:0]       rdata,
    output logic              cs,
    output logic              sclk,
    output logic              mosi,
    input  logic              miso
);

    sd_pkg::sd_job_t    job;
    sd_pkg::sd_status_t status;
    logic               start;
    logic               sh_go;
    logic [7:0]         sh_tx;
    logic [7:0]         sh_rx;
    logic               sh_done;
    logic               pat_load;
    logic               pat_next;
    logic [7:0]         pat_byte;
    logic               pat_last;

    sd_write_regs i_sd_write_regs (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .cfg_req (cfg_req),
        .ack     (ack),
        .rdata   (rdata),
        .job     (job),
        .start   (start),
        .status  (status)
    );

    sd_block_writer i_sd_block_writer (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .job      (job),
        .status   (status),
        .cs       (cs),
        .sh_go    (sh_go),
        .sh_tx    (sh_tx),
        .sh_rx    (sh_rx),
        .sh_done  (sh_done),
        .pat_load (pat_load),
        .pat_next (pat_next),
        .pat_byte (pat_byte),
        .pat_last (pat_last)
    );

    // Seed comes straight from the register block
    sector_pattern_gen i_sector_pattern_gen (
        .clk       (clk),
        .rst       (rst),
        .load      (pat_load),
        .seed      (job.seed),
        .next      (pat_next),
        .data_byte (pat_byte),
        .last      (pat_last)
    );

    spi_byte_shifter #(
        .clk_div (clk_div)
    ) i_spi_byte_shifter (
        .clk     (clk),
        .rst     (rst),
        .go      (sh_go),
        .tx_byte (sh_tx),
        .rx_byte (sh_rx),
        .done    (sh_done),
        .sclk    (sclk),
        .mosi    (mosi),
        .miso    (miso)
    );

endmodule

// ==== hdl/sector_pattern_gen.sv ====
`timescale 1ns/1ps

module sector_pattern_gen (
    input  logic       clk,
    input  logic       rst,
    input  logic       load,
    input  logic [7:0] seed,
    input  logic       next,
    output logic [7:0] data_byte,
    output logic       last
);

    logic [8:0] count;                // Byte position in the sector

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (load) begin
            count <= '0;
        end else if (next) begin
            count <= count + 9'd1;       // Wraps after byte 511
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            data_byte <= seed;
        end else if (next) begin
            data_byte <= data_byte - 8'd1;   // Decrementing pattern
        end
    end

    assign last = (count == 9'(sd_pkg::sector_bytes - 1));

endmodule

// ==== hdl/spi_byte_shifter.sv ====
`timescale 1ns/1ps

module spi_byte_shifter #(
    parameter int clk_div = 2
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       go,
    input  logic [7:0] tx_byte,
    output logic [7:0] rx_byte,
    output logic       done,
    output logic       sclk,
    output logic       mosi,
    input  logic       miso
);

    localparam int div_w = (clk_div > 1) ? $clog2(clk_div) : 1;

    logic             active;
    logic [div_w-1:0] div_cnt;
    logic [3:0]       half;           // Half sclk periods in this byte
    logic [7:0]       shreg;          // Tx bits out the top, rx bits in the bottom
    logic             miso_q;
    logic             half_end;

    assign half_end = active && (div_cnt == div_w'(clk_div - 1));
    assign rx_byte  = shreg;

    always_ff @(posedge clk) begin
        if (rst) begin
            active  <= 1'b0;
            done    <= 1'b0;
            sclk    <= 1'b0;
            mosi    <= 1'b1;
            div_cnt <= '0;
            half    <= '0;
        end else begin
            done <= 1'b0;
            if (go && !active) begin
                active  <= 1'b1;
                div_cnt <= '0;
                half    <= '0;
                mosi    <= tx_byte[7];   // MSB set up before first rising edge
            end else if (half_end) begin
                div_cnt <= '0;
                half    <= half + 4'd1;
                sclk    <= !half[0];
                if (half[0]) begin
                    mosi <= shreg[6];
                    if (half == 4'd15) begin
                        active <= 1'b0;
                        done   <= 1'b1;
                        mosi   <= 1'b1;  // Line idles high
                    end
                end
            end else if (active) begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // Shift register and miso sample
    always_ff @(posedge clk) begin
        if (go && !active) begin
            shreg <= tx_byte;
        end else if (half_end) begin
            if (!half[0]) begin
                miso_q <= miso;              // Sample on rising sclk
            end else begin
                shreg <= {shreg[6:0], miso_q};
            end
        end
    end

    a_no_go_while_active: assert property (@(posedge clk) disable iff (rst) go |-> !active);

endmodule

// ==== sources.f ====
hdl/sd_pkg.sv
hdl/spi_byte_shifter.sv
hdl/sector_pattern_gen.sv
hdl/sd_block_writer.sv
hdl/sd_write_regs.sv
hdl/sd_write_test_top.sv
verif/sd_card_model.sv
verif/sd_write_checker.sv
verif/tb_sd_write_test.sv

// ==== verif/sd_card_model.sv ====
`timescale 1ns/1ps

module sd_card_model (
    input  logic cs,
    input  logic sclk,
    input  logic mosi,
    output logic miso,
    input  int   reject_at,           // Data block number to reject, 0 for never
    output int   blocks
);

    typedef enum {c_cmd, c_arg, c_token, c_data, c_crc} card_state_t;

    card_state_t st;
    logic [7:0]  rx_sh;
    logic [7:0]  tx_sh;
    logic [7:0]  resp_q[$];           // Bytes queued for miso
    logic [31:0] addr;
    int          bit_cnt;
    int          idx;
    int          seed;
    logic [7:0]  mem[logic [31:0]];   // Written bytes by byte address

    initial begin
        seed    = 99;
        blocks  = 0;
        st      = c_cmd;
        bit_cnt = 0;
        tx_sh   = 8'hFF;
    end

    assign miso = cs ? 1'b1 : tx_sh[7];   // Pulled high when deselected

    task automatic take_byte(input logic [7:0] b);
        int n;
        case (st)
            c_cmd: begin
                if (b[7:6] == 2'b01) begin
                    idx = 0;
                    st  = c_arg;
                end
            end
            c_arg: begin
                if (idx < 4) addr = {addr[23:0], b};
                idx++;
                if (idx == 5) begin       // CRC byte done, R1 after a short delay
                    n = $unsigned($random(seed)) % 3;
                    repeat (n) resp_q.push_back(8'hFF);
                    resp_q.push_back(8'h00);
                    st = c_token;
                end
            end
            c_token: begin
                if (b == 8'hFE) begin
                    idx = 0;
                    st  = c_data;
                end
            end
            c_data: begin
                mem[addr + idx] = b;
                idx++;
                if (idx == 512) begin
                    idx = 0;
                    st  = c_crc;
                end
            end
            default: begin
                idx++;
                if (idx == 2) begin
                    blocks++;
                    if (blocks == reject_at) begin
                        resp_q.push_back(8'h0B);  // CRC error token
                    end else begin
                        resp_q.push_back(8'h05);
                        n = 1 + $unsigned($random(seed)) % 4;
                        repeat (n) resp_q.push_back(8'h00);   // Busy while programming
                    end
                    st = c_cmd;
                end
            end
        endcase
    endtask

    always @(negedge cs) begin
        bit_cnt = 0;
        st      = c_cmd;
        tx_sh   = 8'hFF;
        resp_q.delete();
    end

    // Mode 0, sample on rising sclk
    always @(posedge sclk) begin
        if (!cs) begin
            rx_sh = {rx_sh[6:0], mosi};
            bit_cnt++;
            if (bit_cnt == 8) begin
                bit_cnt = 0;
                take_byte(rx_sh);
            end
        end
    end

    always @(negedge sclk) begin
        if (!cs) begin
            if (bit_cnt == 0) begin
                tx_sh = (resp_q.size() > 0) ? resp_q.pop_front() : 8'hFF;
            end else begin
                tx_sh = {tx_sh[6:0], 1'b1};
            end
        end
    end

endmodule

// ==== verif/sd_write_checker.sv ====
`timescale 1ns/1ps

module sd_write_checker (
    input logic cs,
    input logic sclk,
    input logic mosi
);

    typedef enum {k_cmd, k_arg, k_token, k_data} phase_t;

    int          errors = 0;
    int          sectors_seen = 0;    // Full data blocks in this job
    int          cmds_seen = 0;
    logic [31:0] exp_start = '0;
    logic [7:0]  exp_seed = '0;
    phase_t      phase = k_cmd;
    logic [7:0]  rx_sh;
    logic [31:0] addr;
    int          bit_cnt = 0;
    int          idx = 0;

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("FAILED at %0t ns: %s expected %0h got %0h", $time, what, exp, act);
        end
    endtask

    task automatic begin_job(input logic [31:0] start, input logic [7:0] first);
        exp_start    = start;
        exp_seed     = first;
        cmds_seen    = 0;
        sectors_seen = 0;
    endtask

    task automatic take_byte(input logic [7:0] b);
        logic [7:0] exp_b;
        case (phase)
            k_cmd: begin
                if (b != 8'hFF) begin
                    check_value("mosi command byte", 32'h58, {24'd0, b});
                    idx   = 0;
                    phase = k_arg;
                end
            end
            k_arg: begin
                addr = {addr[23:0], b};
                idx++;
                if (idx == 4) begin
                    // Byte address, sector number times 512
                    check_value("mosi command address",
                                exp_start * 32'd512 + 32'(cmds_seen) * 32'd512, addr);
                    cmds_seen++;
                    phase = k_token;
                end
            end
            k_token: begin
                if (b == 8'hFE) begin
                    idx   = 0;
                    phase = k_data;
                end
            end
            default: begin
                exp_b = exp_seed - 8'(idx);
                check_value($sformatf("mosi data byte %0d", idx), {24'd0, exp_b}, {24'd0, b});
                idx++;
                if (idx == 512) begin
                    sectors_seen++;
                    phase = k_cmd;
                end
            end
        endcase
    endtask

    always @(negedge cs) begin
        bit_cnt = 0;
        phase   = k_cmd;
    end

    always @(posedge sclk) begin
        if (!cs) begin
            rx_sh = {rx_sh[6:0], mosi};
            bit_cnt++;
            if (bit_cnt == 8) begin
                bit_cnt = 0;
                take_byte(rx_sh);
            end
        end
    end

endmodule

// ==== verif/tb_sd_write_test.sv ====
`timescale 1ns/1ps

module tb_sd_write_test;

    localparam int ack_timeout = 20;      // Cycles per handshake phase
    localparam int job_timeout = 100000;  // Status reads per job

    logic             clk;
    logic             rst;
    logic             req;
    sd_pkg::cfg_req_t cfg_req;
    logic             ack;
    logic [31:0]      rdata;
    logic             cs;
    logic             sclk;
    logic             mosi;
    logic             miso;
    int               reject_at;
    int               blocks;
    int               seed;
    int               tests_run;
    int               tests_failed;
    int               errs_at_start;

    sd_write_test_top #(
        .clk_div (2)
    ) i_sd_write_test_top (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .cfg_req (cfg_req),
        .ack     (ack),
        .rdata   (rdata),
        .cs      (cs),
        .sclk    (sclk),
        .mosi    (mosi),
        .miso    (miso)
    );

    sd_card_model card_model (
        .cs        (cs),
        .sclk      (sclk),
        .mosi      (mosi),
        .miso      (miso),
        .reject_at (reject_at),
        .blocks    (blocks)
    );

    sd_write_checker write_check (
        .cs   (cs),
        .sclk (sclk),
        .mosi (mosi)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s at %0t ns", why, $time);
        $display("TESTS FAILED");
        $finish;
    endtask

    task automatic wait_ack(input logic level);
        int n;
        n = 0;
        while (ack !== level && n < ack_timeout) begin
            @(negedge clk);
            n++;
        end
        if (ack !== level) abort_run("Register block did not answer the request in time");
    endtask

    task automatic write_register(input logic [1:0] addr, input logic [31:0] data);
        cfg_req.we    = 1'b1;
        cfg_req.addr  = addr;
        cfg_req.wdata = data;
        req = 1'b1;
        wait_ack(1'b1);
        req = 1'b0;
        wait_ack(1'b0);
    endtask

    task automatic read_register(input logic [1:0] addr, output logic [31:0] data);
        cfg_req.we    = 1'b0;
        cfg_req.addr  = addr;
        cfg_req.wdata = '0;
        req = 1'b1;
        wait_ack(1'b1);
        data = rdata;                     // Valid while ack is high
        req  = 1'b0;
        wait_ack(1'b0);
    endtask

    // Job ends when busy is low and done or err is set
    task automatic poll_until_idle(output sd_pkg::sd_status_t st);
        logic [31:0] rd;
        int n;
        n = 0;
        read_register(sd_pkg::reg_ctrl, rd);
        st = rd[10:0];
        while (!(!st.busy && (st.done || st.err)) && n < job_timeout) begin
            read_register(sd_pkg::reg_ctrl, rd);
            st = rd[10:0];
            n++;
        end
        if (st.busy || !(st.done || st.err)) abort_run("Write job did not finish in time");
    endtask

    task automatic run_job(input logic [31:0] start, input logic [7:0] count,
                           input logic [7:0] first, output sd_pkg::sd_status_t st);
        write_register(sd_pkg::reg_start, start);
        write_register(sd_pkg::reg_count, {24'd0, count});
        write_register(sd_pkg::reg_seed, {24'd0, first});
        write_check.begin_job(start, first);
        write_register(sd_pkg::reg_ctrl, 32'd1);
        poll_until_idle(st);
    endtask

    task automatic check_status(input sd_pkg::sd_status_t st, input logic done,
                                input logic err, input logic [7:0] count);
        write_check.check_value("status.done", done, st.done);
        write_check.check_value("status.err", err, st.err);
        write_check.check_value("status.sectors_done", count, st.sectors_done);
    endtask

    task automatic note_errors();
        errs_at_start = write_check.errors;
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (write_check.errors == errs_at_start) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: fail", tests_run, name);
        end
    endtask

    initial begin
        sd_pkg::sd_status_t st;
        logic [31:0]        rd;
        logic [31:0]        start;
        logic [31:0]        v;
        logic [7:0]         first;
        logic [7:0]         count;
        int                 i;
        int                 j;

        seed         = 99;
        rst          = 1'b1;
        req          = 1'b0;
        cfg_req      = '0;
        reject_at    = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        note_errors();
        write_check.check_value("ack", 32'd0, ack);
        write_check.check_value("cs", 32'd1, cs);
        write_check.check_value("sclk", 32'd0, sclk);
        write_check.check_value("mosi", 32'd1, mosi);
        read_register(sd_pkg::reg_ctrl, rd);
        write_check.check_value("status busy/done/err", 32'd0, rd[10:8]);
        report_test("reset_state");

        note_errors();
        start = $random(seed);
        write_register(sd_pkg::reg_start, start);
        read_register(sd_pkg::reg_start, rd);
        write_check.check_value("rdata reg_start", start, rd);
        v = $random(seed);
        write_register(sd_pkg::reg_count, v);
        read_register(sd_pkg::reg_count, rd);
        write_check.check_value("rdata reg_count", {24'd0, v[7:0]}, rd);
        v = $random(seed);
        write_register(sd_pkg::reg_seed, v);
        read_register(sd_pkg::reg_seed, rd);
        write_check.check_value("rdata reg_seed", {24'd0, v[7:0]}, rd);
        report_test("register_readback");

        note_errors();
        start = $random(seed);
        first = $random(seed);
        run_job(start, 8'd1, first, st);
        check_status(st, 1'b1, 1'b0, 8'd1);
        write_check.check_value("sectors on bus", 32'd1, write_check.sectors_seen);
        for (i = 0; i < 512; i++) begin
            write_check.check_value($sformatf("card memory byte %0d", i), 8'(first - i),
                                    card_model.mem[start * 32'd512 + i]);
        end
        report_test("one_sector");

        note_errors();
        for (j = 0; j < 3; j++) begin
            count = 1 + $unsigned($random(seed)) % 4;
            start = $random(seed);
            first = $random(seed);
            run_job(start, count, first, st);
            check_status(st, 1'b1, 1'b0, count);
            write_check.check_value("sectors on bus", count, write_check.sectors_seen);
        end
        report_test("random_jobs");

        note_errors();
        reject_at = blocks + 2;           // Second block of the next job
        start     = $random(seed);
        first     = $random(seed);
        run_job(start, 8'd3, first, st);
        check_status(st, 1'b0, 1'b1, 8'd1);
        write_check.check_value("sectors on bus", 32'd2, write_check.sectors_seen);
        reject_at = 0;
        report_test("reject_second");

        note_errors();
        start = $random(seed);
        first = $random(seed);
        write_register(sd_pkg::reg_start, start);
        write_register(sd_pkg::reg_count, 32'd2);
        write_register(sd_pkg::reg_seed, {24'd0, first});
        write_check.begin_job(start, first);
        write_register(sd_pkg::reg_ctrl, 32'd1);
        read_register(sd_pkg::reg_ctrl, rd);
        write_check.check_value("status.busy", 32'd1, rd[10]);
        // New start and count, then a go that must be ignored
        write_register(sd_pkg::reg_start, start + 32'd100);
        write_register(sd_pkg::reg_count, 32'd4);
        write_register(sd_pkg::reg_ctrl, 32'd1);
        poll_until_idle(st);
        check_status(st, 1'b1, 1'b0, 8'd2);
        write_check.check_value("sectors on bus", 32'd2, write_check.sectors_seen);
        report_test("go_while_busy");

        $display("tests run %0d, tests failed %0d, mismatches %0d",
                 tests_run, tests_failed, write_check.errors);
        if (tests_failed == 0 && write_check.errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
